//--- verilog/ray_xform_pkg.sv
// ray transform package
// Q16.16 fixed-point types, pipeline latencies and the row sequencer states

package ray_xform_pkg;

  // number formats
  localparam int FIXED_W   = 32;
  localparam int PROD_W    = 2 * FIXED_W;
  localparam int FRAC_BITS = 16;

  // signed Q16.16 coordinate, matrix element or result
  typedef logic signed [FIXED_W-1:0] fixed_t;

  // full-width product before rescaling
  typedef logic signed [PROD_W-1:0] prod_t;

  // component index: 0 = x, 1 = y, 2 = z
  typedef logic [1:0] axis_t;

  localparam axis_t AXIS_X = 2'd0;
  localparam axis_t AXIS_Y = 2'd1;
  localparam axis_t AXIS_Z = 2'd2;

  // pipeline depths in clock edges
  localparam int MULT_LAT = 3;
  localparam int ADD_LAT  = 1;

  // multiplier plus two adder levels
  localparam int TREE_LAT = MULT_LAT + 2 * ADD_LAT;

  // operand register in front of the trees
  localparam int SEL_LAT = 1;

  // start edge to first result, 6 with the values above
  localparam int CALC_LAT = SEL_LAT + TREE_LAT;

  // one state per matrix row, plus idle
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ROW_X = 2'd1,
    ROW_Y = 2'd2,
    ROW_Z = 2'd3
  } seq_state_t;

endpackage

//--- verilog/delay_line.sv
// register shift line
// delays a vector by LAT clock edges, all stages cleared by reset

`timescale 1ns/1ps

module delay_line #(
  parameter int LAT   = 1,
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] stage [LAT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < LAT; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < LAT; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign dout = stage[LAT-1];

endmodule

//--- verilog/fx_mult.sv
// pipelined signed Q16.16 multiplier
// three stages: operand register, full product, rescale and truncate

`timescale 1ns/1ps

module fx_mult (
  input  logic                  clk,
  input  logic                  rst,
  input  ray_xform_pkg::fixed_t a,
  input  ray_xform_pkg::fixed_t b,
  output ray_xform_pkg::fixed_t p
);

  ray_xform_pkg::fixed_t a_q;
  ray_xform_pkg::fixed_t b_q;
  ray_xform_pkg::prod_t  prod_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      a_q    <= '0;
      b_q    <= '0;
      prod_q <= '0;
      p      <= '0;
    end else begin
      // stage 1
      a_q <= a;
      b_q <= b;

      // stage 2, sign-extend both so the product keeps all 64 bits
      prod_q <= ray_xform_pkg::prod_t'(a_q) * ray_xform_pkg::prod_t'(b_q);

      // stage 3: arithmetic shift by the fraction width, keep the low word
      p <= prod_q[ray_xform_pkg::FRAC_BITS +: ray_xform_pkg::FIXED_W];
    end
  end

endmodule

//--- verilog/dot3_tree.sv
// row dot product a*x + b*y + c*z, optionally plus an offset term
// three multipliers feeding a two-level registered adder tree

`timescale 1ns/1ps

module dot3_tree #(
  parameter bit HAS_OFFSET = 1'b1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  ray_xform_pkg::fixed_t a,
  input  ray_xform_pkg::fixed_t b,
  input  ray_xform_pkg::fixed_t c,
  input  ray_xform_pkg::fixed_t x,
  input  ray_xform_pkg::fixed_t y,
  input  ray_xform_pkg::fixed_t z,
  input  ray_xform_pkg::fixed_t offset,
  output ray_xform_pkg::fixed_t result
);

  ray_xform_pkg::fixed_t ax;
  ray_xform_pkg::fixed_t by;
  ray_xform_pkg::fixed_t cz;

  // first adder level
  ray_xform_pkg::fixed_t sum_ab;
  ray_xform_pkg::fixed_t sum_cz;

  fx_mult mult_ax (.clk(clk), .rst(rst), .a(a), .b(x), .p(ax));
  fx_mult mult_by (.clk(clk), .rst(rst), .a(b), .b(y), .p(by));
  fx_mult mult_cz (.clk(clk), .rst(rst), .a(c), .b(z), .p(cz));

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_ab <= '0;
    end else begin
      sum_ab <= ax + by;
    end
  end

  if (HAS_OFFSET) begin : g_offset
    ray_xform_pkg::fixed_t offset_d;

    // offset waits out the multiplier so it meets c*z
    delay_line #(
      .LAT   (ray_xform_pkg::MULT_LAT),
      .WIDTH (ray_xform_pkg::FIXED_W)
    ) offset_dly (
      .clk  (clk),
      .rst  (rst),
      .din  (offset),
      .dout (offset_d)
    );

    always_ff @(posedge clk) begin
      if (rst) begin
        sum_cz <= '0;
      end else begin
        sum_cz <= cz + offset_d;
      end
    end
  end else begin : g_no_offset
    // no partner for c*z, just hold it one adder level
    delay_line #(
      .LAT   (ray_xform_pkg::ADD_LAT),
      .WIDTH (ray_xform_pkg::FIXED_W)
    ) cz_dly (
      .clk  (clk),
      .rst  (rst),
      .din  (cz),
      .dout (sum_cz)
    );
  end

  // second adder level, sums wrap modulo 2^32
  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else begin
      result <= sum_ab + sum_cz;
    end
  end

endmodule

//--- verilog/operand_select.sv
// operand selector for the transform trees
// latches ray and triangle on an accepted start, then issues one matrix row per cycle

`timescale 1ns/1ps

module operand_select (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start_ok,
  input  logic                  row_go,
  input  ray_xform_pkg::axis_t  row_sel,
  input  ray_xform_pkg::fixed_t m11, m12, m13,
  input  ray_xform_pkg::fixed_t m21, m22, m23,
  input  ray_xform_pkg::fixed_t m31, m32, m33,
  input  ray_xform_pkg::fixed_t trans_x, trans_y, trans_z,
  input  ray_xform_pkg::fixed_t origin_x, origin_y, origin_z,
  input  ray_xform_pkg::fixed_t dir_x, dir_y, dir_z,
  output ray_xform_pkg::fixed_t row_a, row_b, row_c, row_t,
  output ray_xform_pkg::fixed_t org_x, org_y, org_z,
  output ray_xform_pkg::fixed_t dir_x_q, dir_y_q, dir_z_q
);

  // latched triangle record
  ray_xform_pkg::fixed_t mat [9];
  ray_xform_pkg::fixed_t trn [3];

  // latched ray
  ray_xform_pkg::fixed_t ray_o [3];
  ray_xform_pkg::fixed_t ray_d [3];

  always_ff @(posedge clk) begin
    if (start_ok) begin
      mat   <= '{m11, m12, m13, m21, m22, m23, m31, m32, m33};
      trn   <= '{trans_x, trans_y, trans_z};
      ray_o <= '{origin_x, origin_y, origin_z};
      ray_d <= '{dir_x, dir_y, dir_z};
    end
  end

  // row register, zeros between rays
  always_ff @(posedge clk) begin
    if (rst || !row_go) begin
      row_a <= '0;
      row_b <= '0;
      row_c <= '0;
      row_t <= '0;
    end else begin
      row_a <= mat[3*row_sel];
      row_b <= mat[3*row_sel+1];
      row_c <= mat[3*row_sel+2];
      row_t <= trn[row_sel];
    end
  end

  // ray copy registered beside the row, so a start in ROW_Z
  // cannot swap the vector under the last row of the previous ray
  always_ff @(posedge clk) begin
    org_x   <= ray_o[0];
    org_y   <= ray_o[1];
    org_z   <= ray_o[2];
    dir_x_q <= ray_d[0];
    dir_y_q <= ray_d[1];
    dir_z_q <= ray_d[2];
  end

endmodule

//--- verilog/prime_seq.sv
// row sequencer for the transform unit
// accepts start, steps rows x, y, z and tracks valid/axis down the pipeline

`timescale 1ns/1ps

module prime_seq (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  output logic                 start_ok,
  output logic                 row_go,
  output ray_xform_pkg::axis_t row_sel,
  output logic                 out_valid,
  output ray_xform_pkg::axis_t out_axis,
  output logic                 busy
);

  ray_xform_pkg::seq_state_t state;
  ray_xform_pkg::seq_state_t state_nxt;

  // start is taken when idle or on the last row of the previous ray
  assign start_ok = start &&
    (state == ray_xform_pkg::IDLE || state == ray_xform_pkg::ROW_Z);

  always_comb begin
    case (state)
      ray_xform_pkg::IDLE:  state_nxt = start_ok ? ray_xform_pkg::ROW_X : ray_xform_pkg::IDLE;
      ray_xform_pkg::ROW_X: state_nxt = ray_xform_pkg::ROW_Y;
      ray_xform_pkg::ROW_Y: state_nxt = ray_xform_pkg::ROW_Z;
      default:              state_nxt = start_ok ? ray_xform_pkg::ROW_X : ray_xform_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ray_xform_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    case (state)
      ray_xform_pkg::ROW_Y: row_sel = ray_xform_pkg::AXIS_Y;
      ray_xform_pkg::ROW_Z: row_sel = ray_xform_pkg::AXIS_Z;
      default:              row_sel = ray_xform_pkg::AXIS_X;
    endcase
  end

  assign row_go = (state != ray_xform_pkg::IDLE);
  assign busy   = row_go;

  // valid and axis follow the operands: one select edge plus the tree
  delay_line #(
    .LAT   (ray_xform_pkg::SEL_LAT + ray_xform_pkg::TREE_LAT),
    .WIDTH (1 + $bits(ray_xform_pkg::axis_t))
  ) tag_dly (
    .clk  (clk),
    .rst  (rst),
    .din  ({row_go, row_sel}),
    .dout ({out_valid, out_axis})
  );

endmodule

//--- verilog/prime_calc.sv
// ray into triangle space transform, Q16.16 fixed point
// originp = M*origin + T and dirp = M*dir, one component per cycle x, y, z
// first component six cycles after an accepted start

`timescale 1ns/1ps

module prime_calc (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  ray_xform_pkg::fixed_t origin_x, origin_y, origin_z,
  input  ray_xform_pkg::fixed_t dir_x, dir_y, dir_z,
  input  ray_xform_pkg::fixed_t m11, m12, m13,
  input  ray_xform_pkg::fixed_t m21, m22, m23,
  input  ray_xform_pkg::fixed_t m31, m32, m33,
  input  ray_xform_pkg::fixed_t trans_x, trans_y, trans_z,
  output ray_xform_pkg::fixed_t originp,
  output ray_xform_pkg::fixed_t dirp,
  output logic                  out_valid,
  output ray_xform_pkg::axis_t  out_axis,
  output logic                  busy
);

  logic                  start_ok;
  logic                  row_go;
  ray_xform_pkg::axis_t  row_sel;

  ray_xform_pkg::fixed_t row_a, row_b, row_c, row_t;
  ray_xform_pkg::fixed_t org_x, org_y, org_z;
  ray_xform_pkg::fixed_t dir_x_q, dir_y_q, dir_z_q;

  prime_seq seq (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .start_ok  (start_ok),
    .row_go    (row_go),
    .row_sel   (row_sel),
    .out_valid (out_valid),
    .out_axis  (out_axis),
    .busy      (busy)
  );

  operand_select opsel (
    .clk      (clk),
    .rst      (rst),
    .start_ok (start_ok),
    .row_go   (row_go),
    .row_sel  (row_sel),
    .m11      (m11), .m12(m12), .m13(m13),
    .m21      (m21), .m22(m22), .m23(m23),
    .m31      (m31), .m32(m32), .m33(m33),
    .trans_x  (trans_x), .trans_y(trans_y), .trans_z(trans_z),
    .origin_x (origin_x), .origin_y(origin_y), .origin_z(origin_z),
    .dir_x    (dir_x), .dir_y(dir_y), .dir_z(dir_z),
    .row_a    (row_a), .row_b(row_b), .row_c(row_c), .row_t(row_t),
    .org_x    (org_x), .org_y(org_y), .org_z(org_z),
    .dir_x_q  (dir_x_q), .dir_y_q(dir_y_q), .dir_z_q(dir_z_q)
  );

  // origin: matrix row plus translation
  dot3_tree #(.HAS_OFFSET(1'b1)) org_tree (
    .clk    (clk),
    .rst    (rst),
    .a      (row_a), .b(row_b), .c(row_c),
    .x      (org_x), .y(org_y), .z(org_z),
    .offset (row_t),
    .result (originp)
  );

  // direction is not translated
  dot3_tree #(.HAS_OFFSET(1'b0)) dir_tree (
    .clk    (clk),
    .rst    (rst),
    .a      (row_a), .b(row_b), .c(row_c),
    .x      (dir_x_q), .y(dir_y_q), .z(dir_z_q),
    .offset (),
    .result (dirp)
  );

endmodule

//--- sim/prime_calc_asserts.sv
// concurrent checks on sequencing and output tags of the transform unit

`timescale 1ns/1ps

module prime_calc_asserts (
  input logic                 clk,
  input logic                 rst,
  input logic                 start_ok,
  input logic                 out_valid,
  input ray_xform_pkg::axis_t out_axis,
  input logic                 busy
);

  // busy cycles since the last accepted start
  int busy_run;

  always_ff @(posedge clk) begin
    if (rst || !busy || start_ok) begin
      busy_run <= 0;
    end else begin
      busy_run <= busy_run + 1;
    end
  end

  valid_low_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high after a reset edge");

  // x result sits after edge +6, seen at the sample one edge later
  start_to_x: assert property (@(posedge clk) disable iff (rst)
    $past(start_ok, 7) |-> (out_valid && out_axis == 2'd0))
    else $error("no x result 6 cycles after an accepted start");

  axis_x_to_y: assert property (@(posedge clk) disable iff (rst)
    (out_valid && out_axis == 2'd0) |=> (out_valid && out_axis == 2'd1))
    else $error("y result did not follow x");

  axis_y_to_z: assert property (@(posedge clk) disable iff (rst)
    (out_valid && out_axis == 2'd1) |=> (out_valid && out_axis == 2'd2))
    else $error("z result did not follow y");

  busy_bounded: assert property (@(posedge clk) disable iff (rst)
    busy |-> busy_run < 3)
    else $error("busy held longer than three rows without a new start");

endmodule

bind prime_calc prime_calc_asserts asserts_i (
  .clk       (clk),
  .rst       (rst),
  .start_ok  (start_ok),
  .out_valid (out_valid),
  .out_axis  (out_axis),
  .busy      (busy)
);

//--- sim/tb_prime_calc.sv
// testbench for the ray transform unit
// directed and random rays checked against a Q16.16 reference model

`timescale 1ns/1ps

module tb_prime_calc;

  localparam int NUM_RANDOM     = 16;
  localparam int NUM_B2B        = 4;
  localparam int NUM_WRAP       = 3;
  localparam int NUM_RAYS       = 1 + NUM_RANDOM + NUM_B2B + 1 + 1 + NUM_WRAP;
  localparam int TIMEOUT_CYCLES = 20 * NUM_RAYS + 200;
  localparam int FIRST_LAT      = 6;
  localparam ray_xform_pkg::fixed_t ONE = 32'sh0001_0000;

  logic clk, rst, start;
  ray_xform_pkg::fixed_t origin_x, origin_y, origin_z, dir_x, dir_y, dir_z;
  ray_xform_pkg::fixed_t m11, m12, m13, m21, m22, m23, m31, m32, m33;
  ray_xform_pkg::fixed_t trans_x, trans_y, trans_z;
  ray_xform_pkg::fixed_t originp, dirp;
  logic out_valid, busy;
  ray_xform_pkg::axis_t out_axis;

  // expected results with one entry per output component
  ray_xform_pkg::fixed_t exp_org[$];
  ray_xform_pkg::fixed_t exp_dir[$];
  ray_xform_pkg::axis_t  exp_axis[$];
  int model_row, errors, checks, cycle_count, valid_run, max_run;

  prime_calc UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // each product truncated on its own and the sums wrap at 32 bits
  function automatic ray_xform_pkg::fixed_t ref_dot(input ray_xform_pkg::fixed_t a, b, c,
                                                    input ray_xform_pkg::fixed_t x, y, z, t);
    longint pa, pb, pc;
    pa = (longint'(a) * longint'(x)) >>> 16;
    pb = (longint'(b) * longint'(y)) >>> 16;
    pc = (longint'(c) * longint'(z)) >>> 16;
    return ray_xform_pkg::fixed_t'(pa) + ray_xform_pkg::fixed_t'(pb) +
           ray_xform_pkg::fixed_t'(pc) + t;
  endfunction

  // about +-64.0 normally and any 32-bit pattern when wide
  function automatic ray_xform_pkg::fixed_t rand_value(input bit wide);
    if (wide) begin
      return ray_xform_pkg::fixed_t'($urandom());
    end
    return ray_xform_pkg::fixed_t'(int'($urandom_range(32'd8388608, 32'd0)) - 4194304);
  endfunction

  task automatic check_fixed(input string name, input ray_xform_pkg::fixed_t got,
                             input ray_xform_pkg::fixed_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_axis(input string name, input ray_xform_pkg::axis_t got,
                            input ray_xform_pkg::axis_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic set_random_inputs(input bit wide);
    {origin_x, origin_y, origin_z} = {rand_value(wide), rand_value(wide), rand_value(wide)};
    {dir_x, dir_y, dir_z} = {rand_value(wide), rand_value(wide), rand_value(wide)};
    {m11, m12, m13} = {rand_value(wide), rand_value(wide), rand_value(wide)};
    {m21, m22, m23} = {rand_value(wide), rand_value(wide), rand_value(wide)};
    {m31, m32, m33} = {rand_value(wide), rand_value(wide), rand_value(wide)};
    {trans_x, trans_y, trans_z} = {rand_value(wide), rand_value(wide), rand_value(wide)};
  endtask

  task automatic set_identity();
    set_random_inputs(1'b0);
    {m11, m12, m13} = {ONE, 32'sd0, 32'sd0};
    {m21, m22, m23} = {32'sd0, ONE, 32'sd0};
    {m31, m32, m33} = {32'sd0, 32'sd0, ONE};
    {trans_x, trans_y, trans_z} = {32'sd0, 32'sd0, 32'sd0};
  endtask

  // one-cycle strobe that returns just after the sampling edge
  task automatic issue_start();
    start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((exp_org.size() != 0 || model_row != 0) && n < 60) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (exp_org.size() != 0) begin
      $display("results still pending %0d cycles after the last start", n);
      errors++;
    end
    repeat (2) @(posedge clk);
    #1;
  endtask

  // sequencer model decides acceptance and queues the expected rows
  always @(negedge clk) begin
    if (rst) begin
      model_row = 0;
    end else if (start && (model_row == 0 || model_row == 3)) begin
      exp_axis.push_back(2'd0);
      exp_org.push_back(ref_dot(m11, m12, m13, origin_x, origin_y, origin_z, trans_x));
      exp_dir.push_back(ref_dot(m11, m12, m13, dir_x, dir_y, dir_z, 32'sd0));
      exp_axis.push_back(2'd1);
      exp_org.push_back(ref_dot(m21, m22, m23, origin_x, origin_y, origin_z, trans_y));
      exp_dir.push_back(ref_dot(m21, m22, m23, dir_x, dir_y, dir_z, 32'sd0));
      exp_axis.push_back(2'd2);
      exp_org.push_back(ref_dot(m31, m32, m33, origin_x, origin_y, origin_z, trans_z));
      exp_dir.push_back(ref_dot(m31, m32, m33, dir_x, dir_y, dir_z, 32'sd0));
      model_row = 1;
    end else if (model_row == 3) begin
      model_row = 0;
    end else if (model_row != 0) begin
      model_row = model_row + 1;
    end
  end

  // outputs compared at the falling edge where they are stable
  always @(negedge clk) begin
    if (!rst && out_valid) begin
      valid_run = valid_run + 1;
      if (valid_run > max_run) begin
        max_run = valid_run;
      end
      if (exp_org.size() == 0) begin
        $display("out_valid was high while no result was expected");
        errors++;
      end else begin
        check_axis("out_axis", out_axis, exp_axis.pop_front());
        check_fixed("originp", originp, exp_org.pop_front());
        check_fixed("dirp", dirp, exp_dir.pop_front());
      end
    end else begin
      valid_run = 0;
    end
  end

  initial begin
    int lat;
    bit seen;
    void'($urandom(25));
    {errors, checks, valid_run, max_run, model_row} = '0;
    rst = 1'b1;
    start = 1'b0;
    set_random_inputs(1'b0);
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    repeat (2) @(posedge clk);
    #1;

    // identity matrix gives the ray back six cycles after start
    set_identity();
    issue_start();
    if (!busy) begin
      $display("busy was low in the first row after an accepted start");
      errors++;
    end
    lat = 0;
    seen = 1'b0;
    while (!seen && lat < 20) begin
      @(posedge clk);
      #1;
      lat++;
      seen = out_valid;
    end
    if (!seen || lat != FIRST_LAT) begin
      $display("first result came %0d cycles after start, expected %0d", lat, FIRST_LAT);
      errors++;
    end
    drain();

    repeat (NUM_RANDOM) begin
      set_random_inputs(1'b0);
      issue_start();
      drain();
    end

    // each start lands on the ROW_Z cycle of the ray before
    max_run = 0;
    for (int i = 0; i < NUM_B2B; i++) begin
      set_random_inputs(1'b0);
      issue_start();
      if (i < NUM_B2B - 1) begin
        repeat (2) @(posedge clk);
        #1;
      end
    end
    drain();
    if (max_run < 3 * NUM_B2B) begin
      $display("back-to-back rays gave only %0d consecutive valid cycles", max_run);
      errors++;
    end

    // starts in ROW_X and ROW_Y must be dropped
    set_random_inputs(1'b0);
    issue_start();
    set_random_inputs(1'b0);
    start = 1'b1;
    @(posedge clk);
    #1 set_random_inputs(1'b0);
    @(posedge clk);
    #1 start = 1'b0;
    @(posedge clk);
    #1;
    if (busy) begin
      $display("busy still high after the third row, a start in ROW_X or ROW_Y was taken");
      errors++;
    end
    drain();

    // inputs move after the start edge while the latched copy is used
    set_random_inputs(1'b0);
    issue_start();
    repeat (8) begin
      set_random_inputs(1'b0);
      @(posedge clk);
      #1;
    end
    drain();

    repeat (NUM_WRAP) begin
      set_random_inputs(1'b1);
      issue_start();
      drain();
    end

    if (exp_org.size() != 0) begin
      $display("%0d expected results never appeared", exp_org.size());
      errors++;
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
verilog/ray_xform_pkg.sv
verilog/delay_line.sv
verilog/fx_mult.sv
verilog/dot3_tree.sv
verilog/operand_select.sv
verilog/prime_seq.sv
verilog/prime_calc.sv
sim/prime_calc_asserts.sv
sim/tb_prime_calc.sv

//--- run_sim.sh
#!/bin/sh
# build the prime_calc testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_prime_calc -o tb_prime_calc \
  && ./obj_dir/tb_prime_calc | tee /dev/stderr | grep -qx "TEST PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
